// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////////////////

  // bits of a byte address that the memory decodes
  localparam int MEM_ADDR_BITS = 16;
  localparam int BLOCK_OFFSET_BITS = 3;
  localparam int NUM_SET_BITS = 5;
  localparam int NUM_TAG_BITS = MEM_ADDR_BITS - NUM_SET_BITS - BLOCK_OFFSET_BITS;
  localparam int NUM_SETS = 1 << NUM_SET_BITS;

  // fetch, queue head, send entry
  localparam int STORE_RD_PORTS = 3;

  //////////////////////////////////////////////////////////////////////
  // request queue
  //////////////////////////////////////////////////////////////////////

  localparam int INST_BUFFER_LEN = 6;
  // tail can sit one past the last entry
  localparam int QUEUE_PTR_BITS = $clog2(INST_BUFFER_LEN + 1);
  localparam int NUM_INST_PREFETCH = 4;
  localparam int NUM_CAM_TAGS = 1 + NUM_INST_PREFETCH;

  //////////////////////////////////////////////////////////////////////
  // memory port
  //////////////////////////////////////////////////////////////////////

  // response tag 0 is a refusal
  localparam int MEM_TAG_BITS = 4;
  localparam int BUS_CMD_BITS = 2;
  localparam logic [BUS_CMD_BITS-1:0] BUS_NONE = 2'h0;
  localparam logic [BUS_CMD_BITS-1:0] BUS_LOAD = 2'h1;

  // one returned block, slot 0 is the low word (addr bit 2 clear)
  typedef union packed {
    logic [63:0]      dword;
    logic [1:0][31:0] slot;
  } fetch_block_u;

endpackage

`default_nettype wire

// File: cache_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_store (
  input  logic clock,
  input  logic reset,

  // read ports, all combinational
  input  logic [icache_pkg::STORE_RD_PORTS-1:0] rd_en,
  input  logic [icache_pkg::STORE_RD_PORTS-1:0][icache_pkg::NUM_SET_BITS-1:0] rd_idx,
  input  logic [icache_pkg::STORE_RD_PORTS-1:0][icache_pkg::NUM_TAG_BITS-1:0] rd_tag,

  // single fill port
  input  logic wr_en,
  input  logic [icache_pkg::NUM_SET_BITS-1:0] wr_idx,
  input  logic [icache_pkg::NUM_TAG_BITS-1:0] wr_tag,
  input  logic [63:0] wr_data,

  output logic [icache_pkg::STORE_RD_PORTS-1:0][63:0] rd_data,
  output logic [icache_pkg::STORE_RD_PORTS-1:0] rd_valid
);
  import icache_pkg::*;

  logic [NUM_SETS-1:0] valid;
  logic [NUM_TAG_BITS-1:0] tags [NUM_SETS];
  logic [63:0] data [NUM_SETS];

  //////////////////////////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tags[wr_idx] <= wr_tag;
      data[wr_idx] <= wr_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lookup
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int p = 0; p < STORE_RD_PORTS; p++) begin
      rd_data[p] = data[rd_idx[p]];
      // hit needs enable, a live set and a tag match
      rd_valid[p] = rd_en[p] & valid[rd_idx[p]] & (tags[rd_idx[p]] == rd_tag[p]);
    end
  end

  // a fill with a floating index would corrupt an unknown set
  a_wr_idx_known: assert property (
    @(posedge clock) disable iff (reset)
    wr_en |-> !$isunknown(wr_idx)
  );

endmodule

`default_nettype wire

// File: addr_cam.sv
`timescale 1ns/1ps
`default_nettype none

module addr_cam (
  // fetch block first, then the prefetch blocks
  input  logic [icache_pkg::NUM_CAM_TAGS-1:0][63:0] lookup_addr,
  input  logic [icache_pkg::INST_BUFFER_LEN-1:0][63:0] entry_addr,
  input  logic [icache_pkg::INST_BUFFER_LEN-1:0] entry_valid,
  output logic [icache_pkg::NUM_CAM_TAGS-1:0][icache_pkg::INST_BUFFER_LEN-1:0] hits
);
  import icache_pkg::*;

  // block address compare, offset bits ignored
  always_comb begin
    for (int t = 0; t < NUM_CAM_TAGS; t++) begin
      for (int e = 0; e < INST_BUFFER_LEN; e++) begin
        hits[t][e] = entry_valid[e] &
          (lookup_addr[t][63:BLOCK_OFFSET_BITS] == entry_addr[e][63:BLOCK_OFFSET_BITS]);
      end
    end
  end

endmodule

`default_nettype wire

// File: icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic clock,
  input  logic reset,
  input  logic [63:0] fetch_addr,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  input  icache_pkg::fetch_block_u mem_data,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
  output icache_pkg::fetch_block_u block_data,
  output logic block_valid,
  output logic [icache_pkg::BUS_CMD_BITS-1:0] mem_command,
  output logic [icache_pkg::MEM_ADDR_BITS-1:0] mem_addr
);
  import icache_pkg::*;

  // store ports: 0 fetch, 1 queue head, 2 entry at send pointer
  logic [STORE_RD_PORTS-1:0] rd_en;
  logic [STORE_RD_PORTS-1:0][NUM_SET_BITS-1:0] rd_idx;
  logic [STORE_RD_PORTS-1:0][NUM_TAG_BITS-1:0] rd_tag;
  logic [STORE_RD_PORTS-1:0][63:0] rd_data;
  logic [STORE_RD_PORTS-1:0] rd_valid;

  logic wr_en;
  logic [NUM_SET_BITS-1:0] wr_idx;
  logic [NUM_TAG_BITS-1:0] wr_tag;
  logic [63:0] wr_data;

  logic [INST_BUFFER_LEN-1:0][63:0] q_addr, q_addr_next;
  logic [INST_BUFFER_LEN-1:0][MEM_TAG_BITS-1:0] q_tag, q_tag_next;
  logic [QUEUE_PTR_BITS-1:0] tail, tail_next;
  logic [QUEUE_PTR_BITS-1:0] send_ptr, send_ptr_next;
  logic [QUEUE_PTR_BITS-1:0] wait_ptr, wait_ptr_next;

  logic [63:0] last_fetch_addr;
  logic [NUM_CAM_TAGS-1:0][63:0] lookup_addr;
  logic [INST_BUFFER_LEN-1:0] entry_valid;
  logic [NUM_CAM_TAGS-1:0][INST_BUFFER_LEN-1:0] cam_hits;

  logic changed_addr;
  logic restart;
  logic send_request;
  logic unanswered_miss;
  logic accepted;
  logic mem_done;

  cache_store u_cache_store (
    .clock   (clock),
    .reset   (reset),
    .rd_en   (rd_en),
    .rd_idx  (rd_idx),
    .rd_tag  (rd_tag),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_tag  (wr_tag),
    .wr_data (wr_data),
    .rd_data (rd_data),
    .rd_valid(rd_valid)
  );

  addr_cam u_addr_cam (
    .lookup_addr(lookup_addr),
    .entry_addr (q_addr),
    .entry_valid(entry_valid),
    .hits       (cam_hits)
  );

  //////////////////////////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_CAM_TAGS; i++) begin
      lookup_addr[i] = {fetch_addr[63:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}} +
                       (64'(i) << BLOCK_OFFSET_BITS);
    end
    for (int e = 0; e < INST_BUFFER_LEN; e++) begin
      entry_valid[e] = (QUEUE_PTR_BITS'(e) < tail);
    end
  end

  assign rd_en[0] = 1'b1;
  assign {rd_tag[0], rd_idx[0]} = fetch_addr[MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS];
  assign rd_en[1] = (tail != '0);
  assign {rd_tag[1], rd_idx[1]} = q_addr[0][MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS];
  assign rd_en[2] = (send_ptr < tail);
  assign {rd_tag[2], rd_idx[2]} = q_addr[send_ptr][MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS];

  assign block_data = rd_data[0];
  assign block_valid = rd_valid[0];

  //////////////////////////////////////////////////////////////////////
  // request issue and return matching
  //////////////////////////////////////////////////////////////////////

  assign changed_addr = (fetch_addr != last_fetch_addr);
  // fetch block neither cached nor queued
  assign restart = ~(|cam_hits[0]) & ~rd_valid[0] & ~send_request;
  assign accepted = send_request & (mem_response != '0);
  assign mem_done = (wait_ptr < send_ptr) && (mem_tag != '0) &&
                    (q_tag[wait_ptr] == mem_tag);

  always_comb begin
    if (send_request) begin
      // refused, so try again next cycle
      unanswered_miss = (mem_response == '0);
    end else if ((tail == '0) && changed_addr) begin
      unanswered_miss = ~rd_valid[0];
    end else begin
      unanswered_miss = rd_en[2] & ~rd_valid[2];
    end
  end

  assign mem_command = send_request ? BUS_LOAD : BUS_NONE;
  assign mem_addr = send_request ? q_addr[send_ptr][MEM_ADDR_BITS-1:0] : '0;

  //////////////////////////////////////////////////////////////////////
  // queue update
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    q_addr_next = q_addr;
    q_tag_next = q_tag;
    tail_next = tail;
    send_ptr_next = send_ptr;
    wait_ptr_next = wait_ptr;

    if (mem_done) begin
      wait_ptr_next = wait_ptr_next + 1'b1;
    end

    // head block now in the store
    if (rd_valid[1]) begin
      q_addr_next = {64'b0, q_addr[INST_BUFFER_LEN-1:1]};
      q_tag_next = {{MEM_TAG_BITS{1'b0}}, q_tag[INST_BUFFER_LEN-1:1]};
      tail_next = tail - 1'b1;
      if (send_ptr != '0) begin
        send_ptr_next = send_ptr - 1'b1;
      end
      if (wait_ptr != '0) begin
        wait_ptr_next = wait_ptr_next - 1'b1;
      end
    end

    if (accepted) begin
      q_tag_next[send_ptr_next] = mem_response;
      send_ptr_next = send_ptr_next + 1'b1;
    end

    if (restart) begin
      q_addr_next[0] = lookup_addr[0];
      q_tag_next[0] = '0;
      tail_next = QUEUE_PTR_BITS'(1);
      send_ptr_next = '0;
      wait_ptr_next = '0;
    end

    // old queue hits mean nothing after a restart
    if (changed_addr) begin
      for (int i = 1; i <= NUM_INST_PREFETCH; i++) begin
        if ((restart | ~(|cam_hits[i])) && (tail_next < INST_BUFFER_LEN)) begin
          q_addr_next[tail_next] = lookup_addr[i];
          q_tag_next[tail_next] = '0;
          tail_next = tail_next + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      last_fetch_addr <= '1;
      send_request <= 1'b0;
      tail <= '0;
      send_ptr <= '0;
      wait_ptr <= '0;
      wr_en <= 1'b0;
    end else begin
      last_fetch_addr <= fetch_addr;
      send_request <= unanswered_miss;
      tail <= tail_next;
      send_ptr <= send_ptr_next;
      wait_ptr <= wait_ptr_next;
      wr_en <= mem_done;
    end
  end

  // fill goes to the entry whose data just came back
  always_ff @(posedge clock) begin
    q_addr <= q_addr_next;
    q_tag <= q_tag_next;
    if (mem_done) begin
      wr_data <= mem_data.dword;
      {wr_tag, wr_idx} <= q_addr[wait_ptr][MEM_ADDR_BITS-1:BLOCK_OFFSET_BITS];
    end
  end

  a_tail_bound: assert property (
    @(posedge clock) disable iff (reset)
    tail <= INST_BUFFER_LEN
  );

  a_send_behind_tail: assert property (
    @(posedge clock) disable iff (reset)
    send_ptr <= tail
  );

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
  input  logic clock,
  input  logic reset,
  input  logic redirect,
  input  logic [63:0] redirect_pc,
  input  icache_pkg::fetch_block_u block_data,
  input  logic block_valid,
  output logic [63:0] fetch_addr,
  output logic [31:0] inst,
  output logic [63:0] inst_pc,
  output logic inst_valid
);
  import icache_pkg::*;

  logic [63:0] pc;

  //////////////////////////////////////////////////////////////////////
  // program counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (inst_valid) begin
      pc <= pc + 64'd4;
    end
  end

  assign fetch_addr = pc;
  assign inst_pc = pc;

  // word select within the block by bit 2
  assign inst = block_data.slot[pc[2]];
  // redirect squashes the instruction at the old pc
  assign inst_valid = block_valid & ~redirect;

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic clock,
  input  logic reset,
  input  logic redirect,
  input  logic [63:0] redirect_pc,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  input  icache_pkg::fetch_block_u mem_data,
  input  logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag,
  output logic [31:0] inst,
  output logic [63:0] inst_pc,
  output logic inst_valid,
  output logic [icache_pkg::BUS_CMD_BITS-1:0] mem_command,
  output logic [icache_pkg::MEM_ADDR_BITS-1:0] mem_addr
);
  import icache_pkg::*;

  logic [63:0] fetch_addr;
  fetch_block_u block_data;
  logic block_valid;

  fetch_stage u_fetch_stage (
    .clock      (clock),
    .reset      (reset),
    .redirect   (redirect),
    .redirect_pc(redirect_pc),
    .block_data (block_data),
    .block_valid(block_valid),
    .fetch_addr (fetch_addr),
    .inst       (inst),
    .inst_pc    (inst_pc),
    .inst_valid (inst_valid)
  );

  icache u_icache (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .mem_response(mem_response),
    .mem_data    (mem_data),
    .mem_tag     (mem_tag),
    .block_data  (block_data),
    .block_valid (block_valid),
    .mem_command (mem_command),
    .mem_addr    (mem_addr)
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  logic clock,
  input  logic reset,
  input  logic refuse_enable,
  input  logic [icache_pkg::BUS_CMD_BITS-1:0] mem_command,
  input  logic [icache_pkg::MEM_ADDR_BITS-1:0] mem_addr,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] mem_response,
  output icache_pkg::fetch_block_u mem_data,
  output logic [icache_pkg::MEM_TAG_BITS-1:0] mem_tag
);
  import icache_pkg::*;

  localparam int RETURN_DELAY = 4;
  localparam logic [31:0] IMAGE_KEY = 32'hc0de0000;

  integer seed = 32'h266b3e70;
  int cycle = 0;
  logic refuse_now = 1'b0;
  logic [MEM_TAG_BITS-1:0] next_tag = 1;
  logic took_load;
  logic was_reset;
  logic refuse_allowed;
  logic [MEM_ADDR_BITS-1:0] load_addr;

  // loads in flight, oldest first
  logic [MEM_TAG_BITS-1:0] pend_tag [$];
  logic [MEM_ADDR_BITS-1:0] pend_addr [$];
  int pend_due [$];

  function automatic logic [31:0] image_word(input logic [MEM_ADDR_BITS-1:0] a);
    return 32'(a) ^ IMAGE_KEY;
  endfunction

  // answer in the same cycle as the command
  assign mem_response = (mem_command == BUS_LOAD && !refuse_now) ? next_tag : '0;

  initial begin
    mem_tag = '0;
    mem_data = '0;
  end

  always @(posedge clock) begin
    took_load = (mem_command == BUS_LOAD) && (mem_response != '0);
    load_addr = mem_addr;
    was_reset = reset;
    refuse_allowed = refuse_enable;
    #2;
    mem_tag = '0;
    mem_data = '0;
    if (was_reset) begin
      pend_tag.delete();
      pend_addr.delete();
      pend_due.delete();
      next_tag = 1;
      refuse_now = 1'b0;
      cycle = 0;
    end else begin
      cycle++;
      if (took_load) begin
        pend_tag.push_back(next_tag);
        pend_addr.push_back(load_addr);
        pend_due.push_back(cycle + RETURN_DELAY - 1);
        // tags rotate 1..15, 0 stays the refusal code
        next_tag = (next_tag == '1) ? 1 : next_tag + 1'b1;
      end
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
        mem_tag = pend_tag.pop_front();
        mem_data.slot[0] = image_word(pend_addr[0]);
        mem_data.slot[1] = image_word(pend_addr[0] + 4);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      refuse_now = refuse_allowed && (($random(seed) & 3) == 0);
    end
  end

endmodule

`default_nettype wire

// File: tb_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
  import icache_pkg::*;

  localparam int CLOCK_PERIOD = 20;
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] IMAGE_KEY = 32'hc0de0000;

  logic clock;
  logic reset;
  logic redirect;
  logic [63:0] redirect_pc;
  logic refuse_enable;
  logic [MEM_TAG_BITS-1:0] mem_response;
  logic [MEM_TAG_BITS-1:0] mem_tag;
  fetch_block_u mem_data;
  logic [31:0] inst;
  logic [63:0] inst_pc;
  logic inst_valid;
  logic [BUS_CMD_BITS-1:0] mem_command;
  logic [MEM_ADDR_BITS-1:0] mem_addr;

  int checks = 0;
  int errors = 0;
  int refusals = 0;
  int cycle_count = 0;
  logic tag_reused;
  logic [MEM_ADDR_BITS-1:0] load_log [$];
  logic [MEM_TAG_BITS-1:0] outstanding [$];

  fetch_top u_fetch_top (
    .clock       (clock),
    .reset       (reset),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mem_response(mem_response),
    .mem_data    (mem_data),
    .mem_tag     (mem_tag),
    .inst        (inst),
    .inst_pc     (inst_pc),
    .inst_valid  (inst_valid),
    .mem_command (mem_command),
    .mem_addr    (mem_addr)
  );

  tb_mem_model u_mem_model (
    .clock        (clock),
    .reset        (reset),
    .refuse_enable(refuse_enable),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // memory image, word at byte address a
  function automatic logic [31:0] expected_inst(input logic [63:0] pc);
    return pc[31:0] ^ IMAGE_KEY;
  endfunction

  task automatic print_summary();
    $display("checks: %0d, errors: %0d", checks, errors);
  endtask

  task automatic do_redirect(input logic [63:0] target);
    @(posedge clock);
    #2;
    redirect = 1'b1;
    redirect_pc = target;
    @(posedge clock);
    #2;
    redirect = 1'b0;
  endtask

  // first_wait counts negedges up to the first valid instruction
  task automatic fetch_sequence(input logic [63:0] start_pc, input int count,
                                output int first_wait);
    logic [63:0] expected_pc;
    int seen;
    int waited;
    expected_pc = start_pc;
    seen = 0;
    waited = 0;
    first_wait = 0;
    while (seen < count) begin
      @(negedge clock);
      waited++;
      if (inst_valid) begin
        if (seen == 0) begin
          first_wait = waited;
        end
        check_equal(inst_pc, expected_pc, "inst_pc");
        check_equal(inst, expected_inst(expected_pc), $sformatf("inst at %h", expected_pc));
        expected_pc += 4;
        seen++;
      end
    end
  endtask

  // bus monitor, tag order and alignment
  always @(negedge clock) begin
    if (reset) begin
      outstanding.delete();
    end else begin
      if (mem_command == BUS_LOAD) begin
        load_log.push_back(mem_addr);
        check_equal(mem_addr[2:0], 0, $sformatf("alignment of load %h", mem_addr));
        if (mem_response == '0) begin
          refusals++;
        end else begin
          tag_reused = 1'b0;
          foreach (outstanding[i]) begin
            if (outstanding[i] == mem_response) begin
              tag_reused = 1'b1;
            end
          end
          check_equal(tag_reused, 1'b0, $sformatf("tag %0d still outstanding", mem_response));
          outstanding.push_back(mem_response);
        end
      end
      if (mem_tag != '0) begin
        if (outstanding.size() == 0) begin
          errors++;
          $display("data returned with tag %0d while no load was outstanding", mem_tag);
        end else begin
          check_equal(mem_tag, outstanding.pop_front(), "returned tag order");
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    reset = 1'b1;
    for (int i = 0; i < 4; i++) begin
      @(negedge clock);
      check_equal(mem_command, BUS_NONE, "mem_command in reset");
      check_equal(inst_valid, 1'b0, "inst_valid in reset");
    end
    @(posedge clock);
    #2;
    reset = 1'b0;
    @(negedge clock);
    check_equal(mem_command, BUS_NONE, "mem_command after reset");
    check_equal(inst_valid, 1'b0, "inst_valid after reset");
  endtask

  task automatic test_sequential_fetch();
    int first_wait;
    fetch_sequence(64'h0, 40, first_wait);
  endtask

  task automatic test_prefetch();
    logic [63:0] base;
    logic found;
    int first_wait;
    base = 64'h800;
    do_redirect(base);
    load_log.delete();
    // demand fetch of these six never reaches block B+32
    fetch_sequence(base, 6, first_wait);
    for (int k = 1; k <= NUM_INST_PREFETCH; k++) begin
      found = 1'b0;
      foreach (load_log[i]) begin
        if (load_log[i] == MEM_ADDR_BITS'(base + 8 * k)) begin
          found = 1'b1;
        end
      end
      check_equal(found, 1'b1, $sformatf("prefetch load of block %h", base + 8 * k));
    end
  endtask

  task automatic test_refusals();
    int first_wait;
    @(posedge clock);
    #2;
    refuse_enable = 1'b1;
    refusals = 0;
    do_redirect(64'h400);
    fetch_sequence(64'h400, 40, first_wait);
    check_equal(refusals != 0, 1'b1, "memory refused at least one load");
    @(posedge clock);
    #2;
    refuse_enable = 1'b0;
  endtask

  task automatic test_redirect();
    int first_wait;
    do_redirect(64'h1234);
    check_equal(inst_pc, 64'h1234, "inst_pc after redirect");
    // odd word, so the upper slot
    fetch_sequence(64'h1234, 10, first_wait);
  endtask

  task automatic test_reuse_hit();
    int first_wait;
    int reloads;
    do_redirect(64'h1234);
    load_log.delete();
    fetch_sequence(64'h1234, 8, first_wait);
    check_equal(first_wait, 1, "cycles to first hit after redirect");
    reloads = 0;
    foreach (load_log[i]) begin
      if (load_log[i] >= 16'h1230 && load_log[i] < 16'h1258) begin
        reloads++;
      end
    end
    check_equal(reloads, 0, "loads of blocks already cached");
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    refuse_enable = 1'b0;
    test_reset_state();
    test_sequential_fetch();
    test_prefetch();
    test_refusals();
    test_redirect();
    test_reuse_hit();
    print_summary();
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // hang guard, several times the expected run length
  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    print_summary();
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
icache_pkg.sv
cache_store.sv
addr_cam.sv
icache.sv
fetch_stage.sv
fetch_top.sv
tb_mem_model.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_icache

sources:
  - files:
      - icache_pkg.sv
      - cache_store.sv
      - addr_cam.sv
      - icache.sv
      - fetch_stage.sv
      - fetch_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_fetch_top.sv
